/* design/rtab_entry_store.sv */
/*
 * Entry array of the replay table with its list and dependency flags.
 * Allocation takes the lowest free entry; the caller never allocates when full.
 * A clearing event in the same cycle as a new wait wins over the wait.
 */
`timescale 1ns/1ns

module rtab_entry_store
    import rtab_pkg::*;
#(
    parameter  int NumEntries = 8,
    localparam int PtrWidth   = $clog2(NumEntries)
) (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,
    // Line check
    input  logic [RTAB_NLINE_WIDTH-1:0]          check_nline_i,
    output logic                                 check_hit_o,
    // Allocation
    input  logic                                 alloc_i,
    input  logic                                 alloc_link_i,
    input  rtab_req_t                            alloc_req_i,
    input  rtab_deps_t                           alloc_deps_i,
    // Pop side
    input  logic                                 take_i,
    input  logic [NumEntries-1:0]                take_sel_i,
    input  logic                                 commit_i,
    input  logic                                 rback_i,
    input  logic [PtrWidth-1:0]                  done_ptr_i,
    input  rtab_deps_t                           rback_deps_i,
    // Blocker events
    input  logic                                 refill_i,
    input  logic [RTAB_NLINE_WIDTH-1:0]          refill_nline_i,
    input  logic                                 miss_ready_i,
    // State toward arbiter and pop FSM
    output logic [NumEntries-1:0]                head_ready_o,
    output logic [NumEntries-1:0]                tail_o,
    output logic [NumEntries-1:0]                valid_o,
    output logic [NumEntries-1:0][PtrWidth-1:0]  next_o,
    output rtab_req_t                            sel_req_o
);

    rtab_req_t [NumEntries-1:0]                req_q;
    logic      [NumEntries-1:0][PtrWidth-1:0]  next_q;

    logic [NumEntries-1:0] valid_q;
    logic [NumEntries-1:0] head_q;
    logic [NumEntries-1:0] tail_q;
    logic [NumEntries-1:0] refill_wait_q;
    logic [NumEntries-1:0] miss_wait_q;

    logic [RTAB_NLINE_WIDTH-1:0] nline [NumEntries];
    logic [NumEntries-1:0] check_match;
    logic [NumEntries-1:0] refill_match;
    logic [NumEntries-1:0] match_tail;

    logic [NumEntries-1:0] free;
    logic [NumEntries-1:0] free_sel;
    logic [PtrWidth-1:0]   alloc_ptr;
    logic [NumEntries-1:0] alloc_vec;
    logic [NumEntries-1:0] link_vec;

    logic [NumEntries-1:0] done_vec;
    logic [NumEntries-1:0] take_vec;
    logic [NumEntries-1:0] commit_vec;
    logic [NumEntries-1:0] rback_vec;

    logic [NumEntries-1:0] head_set, head_rst;
    logic [NumEntries-1:0] tail_set, tail_rst;
    logic [NumEntries-1:0] refill_wait_set, refill_wait_rst;
    logic [NumEntries-1:0] miss_wait_set, miss_wait_rst;

    // Line of each entry and its comparisons
    for (genvar i = 0; i < NumEntries; i++) begin : gen_match
        assign nline[i]        = req_q[i].addr[RTAB_ADDR_WIDTH-1:RTAB_OFFSET_WIDTH];
        assign check_match[i]  = valid_q[i] & (nline[i] == check_nline_i);
        assign refill_match[i] = nline[i] == refill_nline_i;
    end

    assign check_hit_o = |check_match;
    assign match_tail  = check_match & tail_q;

    // Lowest free entry as one-hot and as index
    assign free     = ~valid_q;
    assign free_sel = free & (~free + 1'b1);

    always_comb begin
        alloc_ptr = '0;
        for (int i = 0; i < NumEntries; i++) begin
            if (free_sel[i]) begin
                alloc_ptr = PtrWidth'(i);
            end
        end
    end

    assign alloc_vec = free_sel & {NumEntries{alloc_i | alloc_link_i}};
    assign link_vec  = match_tail & {NumEntries{alloc_link_i}};

    always_comb begin
        done_vec             = '0;
        done_vec[done_ptr_i] = 1'b1;
    end

    assign take_vec   = take_sel_i & {NumEntries{take_i}};
    assign commit_vec = done_vec & {NumEntries{commit_i}};
    assign rback_vec  = done_vec & {NumEntries{rback_i}};

    // New lists start with a head; linked entries wait behind their predecessor
    assign head_set = (alloc_vec & {NumEntries{alloc_i}}) | rback_vec;
    assign head_rst = take_vec | (alloc_vec & {NumEntries{alloc_link_i}});

    // The tail flag moves from the old tail to the linked entry
    assign tail_set = alloc_vec;
    assign tail_rst = link_vec | commit_vec;

    assign refill_wait_set = (alloc_vec & {NumEntries{alloc_deps_i.refill_wait}}) |
                             (rback_vec & {NumEntries{rback_deps_i.refill_wait}});
    assign refill_wait_rst = refill_match & {NumEntries{refill_i}};
    assign miss_wait_set   = (alloc_vec & {NumEntries{alloc_deps_i.miss_slot_wait}}) |
                             (rback_vec & {NumEntries{rback_deps_i.miss_slot_wait}});
    assign miss_wait_rst   = {NumEntries{miss_ready_i}};

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q       <= '0;
            head_q        <= '0;
            tail_q        <= '0;
            refill_wait_q <= '0;
            miss_wait_q   <= '0;
        end else begin
            valid_q       <= (valid_q & ~commit_vec) | alloc_vec;
            head_q        <= (head_q & ~head_rst) | head_set;
            tail_q        <= (tail_q & ~tail_rst) | tail_set;
            refill_wait_q <= (refill_wait_q | refill_wait_set) & ~refill_wait_rst;
            miss_wait_q   <= (miss_wait_q | miss_wait_set) & ~miss_wait_rst;
        end
    end

    // Payloads and list links
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < NumEntries; i++) begin
            if (alloc_vec[i]) begin
                req_q[i] <= alloc_req_i;
            end
            if (link_vec[i]) begin
                next_q[i] <= alloc_ptr;
            end
        end
    end

    assign head_ready_o = valid_q & head_q & ~(refill_wait_q | miss_wait_q);
    assign tail_o       = tail_q;
    assign valid_o      = valid_q;
    assign next_o       = next_q;

    always_comb begin
        sel_req_o = '0;
        for (int i = 0; i < NumEntries; i++) begin
            if (take_sel_i[i]) begin
                sel_req_o = sel_req_o | req_q[i];
            end
        end
    end

    // Lists of one line never fork, so linking finds a single tail
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        alloc_link_i |-> $onehot0(match_tail))
        else $error("rtab store: more than one tail matches the checked line");

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (commit_i || rback_i) |-> valid_q[done_ptr_i])
        else $error("rtab store: commit or rollback names an invalid entry");

endmodule

/* design/rtab_pkg.sv */
/*
 * Shared widths and types of the replay table.
 * Line index is the address above the byte offset inside a 64-byte line.
 * The number of entries is a module parameter and is not defined here.
 */
package rtab_pkg;

    // Cache-line index and byte offset inside a line
    localparam int RTAB_NLINE_WIDTH  = 26;
    localparam int RTAB_OFFSET_WIDTH = 6;
    localparam int RTAB_ADDR_WIDTH   = RTAB_NLINE_WIDTH + RTAB_OFFSET_WIDTH;

    // Requester tag returned with the replayed request
    localparam int RTAB_ID_WIDTH = 4;

    // Payload of one entry, 37 bits
    typedef struct packed {
        logic [RTAB_ADDR_WIDTH-1:0] addr;
        logic [RTAB_ID_WIDTH-1:0]   tag;
        logic                       is_store;
    } rtab_req_t;

    // Blockers of an entry
    // refill_wait waits for the refill of the entry's own line
    // miss_slot_wait waits for the miss handler to accept a new miss
    typedef struct packed {
        logic refill_wait;
        logic miss_slot_wait;
    } rtab_deps_t;

    // Pop FSM
    // POP_HEAD offers the arbitrated list head
    // POP_NEXT offers the next member of the list being walked
    // POP_NEXT_WAIT holds that member under back-pressure
    typedef enum logic [1:0] {
        POP_HEAD      = 2'd0,
        POP_NEXT      = 2'd1,
        POP_NEXT_WAIT = 2'd2
    } rtab_pop_state_e;

endpackage

/* design/rtab_pop_ctrl.sv */
/*
 * Pop FSM of the replay table.
 * After a head is taken, the rest of its list is offered in order.
 * The caller does not accept a pop in the cycle of a rollback.
 */
`timescale 1ns/1ns

module rtab_pop_ctrl
    import rtab_pkg::*;
#(
    parameter  int NumEntries = 8,
    localparam int PtrWidth   = $clog2(NumEntries)
) (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,
    input  logic [NumEntries-1:0]                head_gnt_i,
    input  logic [NumEntries-1:0]                tail_i,
    input  logic [NumEntries-1:0][PtrWidth-1:0]  next_i,
    input  logic                                 pop_ready_i,
    input  logic                                 rback_i,
    output logic                                 pop_valid_o,
    output logic [PtrWidth-1:0]                  pop_ptr_o,
    output logic                                 take_o,
    output logic [NumEntries-1:0]                take_sel_o,
    output logic                                 advance_o
);

    rtab_pop_state_e       state_q, state_d;
    logic [NumEntries-1:0] member_q, member_d;
    logic [NumEntries-1:0] next_sel;
    logic                  in_head;
    logic                  sel_is_tail;

    assign in_head = state_q == POP_HEAD;

    // List members are offered even though their head flag is clear
    assign pop_valid_o = in_head ? |head_gnt_i : 1'b1;
    assign take_sel_o  = in_head ? head_gnt_i : member_q;
    assign take_o      = pop_valid_o & pop_ready_i;
    assign advance_o   = in_head & take_o;

    always_comb begin
        pop_ptr_o = '0;
        for (int i = 0; i < NumEntries; i++) begin
            if (take_sel_o[i]) begin
                pop_ptr_o = PtrWidth'(i);
            end
        end
    end

    assign sel_is_tail = |(take_sel_o & tail_i);
    assign next_sel    = {{(NumEntries - 1){1'b0}}, 1'b1} << next_i[pop_ptr_o];

    always_comb begin
        state_d  = state_q;
        member_d = member_q;
        unique case (state_q)
            POP_HEAD: begin
                if (take_o && !sel_is_tail) begin
                    state_d  = POP_NEXT;
                    member_d = next_sel;
                end
            end
            POP_NEXT: begin
                // First cycle after the predecessor left, its rollback can arrive here
                if (rback_i) begin
                    state_d = POP_HEAD;
                end else if (pop_ready_i) begin
                    if (sel_is_tail) begin
                        state_d = POP_HEAD;
                    end else begin
                        member_d = next_sel;
                    end
                end else begin
                    state_d = POP_NEXT_WAIT;
                end
            end
            POP_NEXT_WAIT: begin
                if (pop_ready_i) begin
                    if (sel_is_tail) begin
                        state_d = POP_HEAD;
                    end else begin
                        state_d  = POP_NEXT;
                        member_d = next_sel;
                    end
                end
            end
            default: begin
                state_d = POP_HEAD;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q  <= POP_HEAD;
            member_q <= '0;
        end else begin
            state_q  <= state_d;
            member_q <= member_d;
        end
    end

    // A rollback follows a transfer, so it never meets a held member or a new transfer
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        rback_i |-> ((state_q != POP_NEXT_WAIT) && !pop_ready_i))
        else $error("rtab pop: rollback outside the cycle after a transfer");

endmodule

/* design/rtab_rr_arbiter.sv */
/*
 * Round-robin arbiter with one-hot grant.
 * A grant that was not taken is held while its requester still asks,
 * so the granted index stays stable under back-pressure.
 */
`timescale 1ns/1ns

module rtab_rr_arbiter #(
    parameter  int NumEntries = 8,
    localparam int PtrWidth   = $clog2(NumEntries)
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic [NumEntries-1:0] req_i,
    input  logic                  advance_i,
    output logic [NumEntries-1:0] gnt_o
);

    logic [PtrWidth-1:0]   prio_q;
    logic [NumEntries-1:0] rr_gnt;
    logic [PtrWidth-1:0]   rr_idx;
    logic [NumEntries-1:0] gnt_q;
    logic [PtrWidth-1:0]   gnt_idx_q;
    logic [PtrWidth-1:0]   gnt_idx;
    logic                  hold_q;
    logic                  use_hold;

    // Scan downwards so the requester closest to the pointer wins
    always_comb begin
        int idx;
        rr_gnt = '0;
        rr_idx = '0;
        for (int i = NumEntries - 1; i >= 0; i--) begin
            idx = (int'(prio_q) + i) % NumEntries;
            if (req_i[idx]) begin
                rr_gnt      = '0;
                rr_gnt[idx] = 1'b1;
                rr_idx      = PtrWidth'(idx);
            end
        end
    end

    assign use_hold = hold_q & (|(gnt_q & req_i));
    assign gnt_o    = use_hold ? gnt_q : rr_gnt;
    assign gnt_idx  = use_hold ? gnt_idx_q : rr_idx;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            prio_q    <= '0;
            gnt_q     <= '0;
            gnt_idx_q <= '0;
            hold_q    <= 1'b0;
        end else begin
            if (advance_i && (|gnt_o)) begin
                prio_q <= (gnt_idx == PtrWidth'(NumEntries - 1)) ? '0 : gnt_idx + 1'b1;
            end
            gnt_q     <= gnt_o;
            gnt_idx_q <= gnt_idx;
            hold_q    <= (|gnt_o) & ~advance_i;
        end
    end

    // The pointer only moves past a requester that actually holds the grant
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        advance_i |-> $onehot(gnt_o))
        else $error("rr arbiter: advance without a grant");

endmodule

/* design/rtab_top.sv */
/*
 * Replay table for a non-blocking data cache.
 * Allocate-and-link needs a hit on check_nline_i for the request's own line.
 * Each pop transfer is followed next cycle by exactly one commit or rollback.
 */
`timescale 1ns/1ns

module rtab_top
    import rtab_pkg::*;
#(
    parameter  int NumEntries = 8,
    localparam int PtrWidth   = $clog2(NumEntries)
) (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    // Line check
    input  logic [RTAB_NLINE_WIDTH-1:0]  check_nline_i,
    output logic                         check_hit_o,
    // Allocation
    input  logic                         alloc_i,
    input  logic                         alloc_link_i,
    input  rtab_req_t                    alloc_req_i,
    input  rtab_deps_t                   alloc_deps_i,
    // Pop
    output logic                         pop_valid_o,
    input  logic                         pop_ready_i,
    output rtab_req_t                    pop_req_o,
    output logic [PtrWidth-1:0]          pop_ptr_o,
    input  logic                         pop_commit_i,
    input  logic                         pop_rback_i,
    input  logic [PtrWidth-1:0]          pop_done_ptr_i,
    input  rtab_deps_t                   rback_deps_i,
    // Blocker events
    input  logic                         refill_i,
    input  logic [RTAB_NLINE_WIDTH-1:0]  refill_nline_i,
    input  logic                         miss_ready_i,
    // Occupancy
    output logic                         empty_o,
    output logic                         full_o
);

    logic [NumEntries-1:0]                head_ready;
    logic [NumEntries-1:0]                head_gnt;
    logic [NumEntries-1:0]                tail;
    logic [NumEntries-1:0]                valid;
    logic [NumEntries-1:0][PtrWidth-1:0]  next;
    logic                                 take;
    logic [NumEntries-1:0]                take_sel;
    logic                                 advance;

    rtab_entry_store #(
        .NumEntries     (NumEntries)
    ) store_i (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .check_nline_i  (check_nline_i),
        .check_hit_o    (check_hit_o),
        .alloc_i        (alloc_i),
        .alloc_link_i   (alloc_link_i),
        .alloc_req_i    (alloc_req_i),
        .alloc_deps_i   (alloc_deps_i),
        .take_i         (take),
        .take_sel_i     (take_sel),
        .commit_i       (pop_commit_i),
        .rback_i        (pop_rback_i),
        .done_ptr_i     (pop_done_ptr_i),
        .rback_deps_i   (rback_deps_i),
        .refill_i       (refill_i),
        .refill_nline_i (refill_nline_i),
        .miss_ready_i   (miss_ready_i),
        .head_ready_o   (head_ready),
        .tail_o         (tail),
        .valid_o        (valid),
        .next_o         (next),
        .sel_req_o      (pop_req_o)
    );

    rtab_rr_arbiter #(
        .NumEntries (NumEntries)
    ) arb_i (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .req_i      (head_ready),
        .advance_i  (advance),
        .gnt_o      (head_gnt)
    );

    rtab_pop_ctrl #(
        .NumEntries  (NumEntries)
    ) pop_ctrl_i (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .head_gnt_i  (head_gnt),
        .tail_i      (tail),
        .next_i      (next),
        .pop_ready_i (pop_ready_i),
        .rback_i     (pop_rback_i),
        .pop_valid_o (pop_valid_o),
        .pop_ptr_o   (pop_ptr_o),
        .take_o      (take),
        .take_sel_o  (take_sel),
        .advance_o   (advance)
    );

    assign empty_o = ~(|valid);
    assign full_o  = &valid;

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (alloc_i || alloc_link_i) |-> !full_o)
        else $error("rtab: allocation while the table is full");

endmodule

/* flist.f */
design/rtab_pkg.sv
design/rtab_rr_arbiter.sv
design/rtab_entry_store.sv
design/rtab_pop_ctrl.sv
design/rtab_top.sv
tests/tb_clock_gen.sv
tests/rtab_tb.sv

/* tests/rtab_tb.sv */
/*
 * Directed testbench of the replay table with 8 entries.
 * Inputs change on the falling edge and outputs are sampled there as well.
 * Every pop transfer is closed by a commit or a rollback in the next cycle.
 */
`timescale 1ns/1ns

module rtab_tb
    import rtab_pkg::*;
();

    localparam int NumEntries    = 8;
    localparam int PtrWidth      = $clog2(NumEntries);
    localparam int ClkPeriodNs   = 10;
    localparam int TestCount     = 5;
    localparam int CyclesPerTest = 200;
    localparam int PopWaitCycles = 50;

    logic                        clk;
    logic                        rst_n;
    logic [RTAB_NLINE_WIDTH-1:0] check_nline;
    logic                        check_hit;
    logic                        alloc;
    logic                        alloc_link;
    rtab_req_t                   alloc_req;
    rtab_deps_t                  alloc_deps;
    logic                        pop_valid;
    logic                        pop_ready;
    rtab_req_t                   pop_req;
    logic [PtrWidth-1:0]         pop_ptr;
    logic                        pop_commit;
    logic                        pop_rback;
    logic [PtrWidth-1:0]         pop_done_ptr;
    rtab_deps_t                  rback_deps;
    logic                        refill;
    logic [RTAB_NLINE_WIDTH-1:0] refill_nline;
    logic                        miss_ready;
    logic                        empty;
    logic                        full;

    int    err_count;
    int    seed;
    string test_name;

    tb_clock_gen #(
        .PeriodNs    (ClkPeriodNs),
        .ResetCycles (3)
    ) clock_gen_i (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    rtab_top #(
        .NumEntries (NumEntries)
    ) rtab_top_i (
        .clk_i          (clk),
        .rst_ni         (rst_n),
        .check_nline_i  (check_nline),
        .check_hit_o    (check_hit),
        .alloc_i        (alloc),
        .alloc_link_i   (alloc_link),
        .alloc_req_i    (alloc_req),
        .alloc_deps_i   (alloc_deps),
        .pop_valid_o    (pop_valid),
        .pop_ready_i    (pop_ready),
        .pop_req_o      (pop_req),
        .pop_ptr_o      (pop_ptr),
        .pop_commit_i   (pop_commit),
        .pop_rback_i    (pop_rback),
        .pop_done_ptr_i (pop_done_ptr),
        .rback_deps_i   (rback_deps),
        .refill_i       (refill),
        .refill_nline_i (refill_nline),
        .miss_ready_i   (miss_ready),
        .empty_o        (empty),
        .full_o         (full)
    );

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED %s %s: expected %b, actual %b", test_name, what, exp, act);
            err_count++;
        end
    endtask

    task automatic check_req(input string what, input rtab_req_t exp, input rtab_req_t act);
        if (act !== exp) begin
            $display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
            err_count++;
        end
    endtask

    task automatic check_ptr(input string what, input logic [PtrWidth-1:0] exp,
                             input logic [PtrWidth-1:0] act);
        if (act !== exp) begin
            $display("FAILED %s %s: expected %0d, actual %0d", test_name, what, exp, act);
            err_count++;
        end
    endtask

    // Line index is the address above the byte offset
    function automatic logic [RTAB_NLINE_WIDTH-1:0] line_of(input rtab_req_t req);
        return req.addr[RTAB_ADDR_WIDTH-1:RTAB_OFFSET_WIDTH];
    endfunction

    task automatic rand_req(output rtab_req_t req);
        req.addr     = RTAB_ADDR_WIDTH'($random(seed));
        req.tag      = RTAB_ID_WIDTH'($random(seed));
        req.is_store = 1'($random(seed));
    endtask

    task automatic alloc_entry(input rtab_req_t req, input rtab_deps_t deps, input bit link);
        if (link) begin
            check_nline = line_of(req);
            alloc_link  = 1'b1;
        end else begin
            alloc = 1'b1;
        end
        alloc_req  = req;
        alloc_deps = deps;
        @(negedge clk);
        alloc      = 1'b0;
        alloc_link = 1'b0;
    endtask

    task automatic check_line(input logic [RTAB_NLINE_WIDTH-1:0] nline, input logic exp);
        check_nline = nline;
        @(negedge clk);
        check_bit("check_hit_o", exp, check_hit);
    endtask

    task automatic expect_blocked(input int cycles);
        repeat (cycles) begin
            check_bit("pop_valid_o while blocked", 1'b0, pop_valid);
            @(negedge clk);
        end
    endtask

    // Waits for an offer and transfers it, optionally with random back-pressure
    task automatic pop_take(input bit random_bp, output rtab_req_t req,
                            output logic [PtrWidth-1:0] ptr);
        int waited;
        bit go;
        waited = 0;
        go     = 1'b0;
        req    = '0;
        ptr    = '0;
        while (pop_valid !== 1'b1 && waited < PopWaitCycles) begin
            @(negedge clk);
            waited++;
        end
        if (pop_valid !== 1'b1) begin
            $display("ERROR in %s: pop_valid_o did not rise within %0d cycles",
                     test_name, PopWaitCycles);
            err_count++;
        end else begin
            req = pop_req;
            ptr = pop_ptr;
            while (!go) begin
                go        = random_bp ? (($random(seed) & 1) == 1) : 1'b1;
                pop_ready = go;
                @(negedge clk);
                if (!go) begin
                    check_bit("pop_valid_o held", 1'b1, pop_valid);
                    check_req("pop_req_o held", req, pop_req);
                    check_ptr("pop_ptr_o held", ptr, pop_ptr);
                end
            end
            pop_ready = 1'b0;
        end
    endtask

    task automatic pop_commit_entry(input logic [PtrWidth-1:0] ptr);
        pop_commit   = 1'b1;
        pop_done_ptr = ptr;
        @(negedge clk);
        pop_commit = 1'b0;
    endtask

    task automatic pop_rollback_entry(input logic [PtrWidth-1:0] ptr, input rtab_deps_t deps);
        pop_rback    = 1'b1;
        pop_done_ptr = ptr;
        rback_deps   = deps;
        @(negedge clk);
        pop_rback  = 1'b0;
        rback_deps = '0;
    endtask

    task automatic single_entry();
        rtab_req_t           req;
        rtab_req_t           got;
        logic [PtrWidth-1:0] ptr;
        test_name = "single_entry";
        check_bit("empty_o after reset", 1'b1, empty);
        check_bit("full_o after reset", 1'b0, full);
        check_bit("pop_valid_o after reset", 1'b0, pop_valid);
        rand_req(req);
        check_line(line_of(req), 1'b0);
        alloc_entry(req, '0, 1'b0);
        check_line(line_of(req), 1'b1);
        check_line(line_of(req) ^ 1'b1, 1'b0);
        pop_take(1'b0, got, ptr);
        check_req("popped payload", req, got);
        // An empty table hands out its lowest entry
        check_ptr("popped pointer", '0, ptr);
        pop_commit_entry(ptr);
        check_bit("empty_o after commit", 1'b1, empty);
    endtask

    task automatic list_order();
        rtab_req_t           exp_reqs[3];
        rtab_req_t           got;
        logic [PtrWidth-1:0] ptr;
        test_name = "list_order";
        rand_req(exp_reqs[0]);
        for (int i = 1; i < 3; i++) begin
            rand_req(exp_reqs[i]);
            // Same line, other offset and tag
            exp_reqs[i].addr[RTAB_ADDR_WIDTH-1:RTAB_OFFSET_WIDTH] = line_of(exp_reqs[0]);
        end
        alloc_entry(exp_reqs[0], '0, 1'b0);
        alloc_entry(exp_reqs[1], '0, 1'b1);
        alloc_entry(exp_reqs[2], '0, 1'b1);
        for (int i = 0; i < 3; i++) begin
            pop_take(1'b0, got, ptr);
            check_req($sformatf("list element %0d", i), exp_reqs[i], got);
            check_ptr($sformatf("list element %0d pointer", i), PtrWidth'(i), ptr);
            pop_commit_entry(ptr);
        end
        check_bit("empty_o after list", 1'b1, empty);
    endtask

    task automatic refill_dependency();
        rtab_req_t           req;
        rtab_req_t           got;
        rtab_deps_t          deps;
        logic [PtrWidth-1:0] ptr;
        test_name = "refill_dependency";
        rand_req(req);
        deps             = '0;
        deps.refill_wait = 1'b1;
        alloc_entry(req, deps, 1'b0);
        expect_blocked(4);
        // A neighbouring line must not release the entry
        refill       = 1'b1;
        refill_nline = line_of(req) ^ 1'b1;
        @(negedge clk);
        refill = 1'b0;
        expect_blocked(5);
        refill       = 1'b1;
        refill_nline = line_of(req);
        @(negedge clk);
        refill = 1'b0;
        check_bit("pop_valid_o after refill", 1'b1, pop_valid);
        pop_take(1'b0, got, ptr);
        check_req("released payload", req, got);
        pop_commit_entry(ptr);
    endtask

    task automatic rollback_replay();
        rtab_req_t           req;
        rtab_req_t           got;
        rtab_deps_t          deps;
        logic [PtrWidth-1:0] ptr;
        logic [PtrWidth-1:0] ptr2;
        test_name = "rollback_replay";
        rand_req(req);
        alloc_entry(req, '0, 1'b0);
        pop_take(1'b0, got, ptr);
        check_req("first pop", req, got);
        check_ptr("first pointer", '0, ptr);
        deps                = '0;
        deps.miss_slot_wait = 1'b1;
        pop_rollback_entry(ptr, deps);
        expect_blocked(5);
        miss_ready = 1'b1;
        @(negedge clk);
        miss_ready = 1'b0;
        check_bit("pop_valid_o after miss ready", 1'b1, pop_valid);
        pop_take(1'b0, got, ptr2);
        check_req("replayed payload", req, got);
        check_ptr("replayed pointer", '0, ptr2);
        pop_commit_entry(ptr2);
        check_bit("empty_o after replay", 1'b1, empty);
    endtask

    task automatic full_and_fair();
        rtab_req_t           exp_reqs[NumEntries];
        bit                  seen[NumEntries];
        rtab_req_t           got;
        logic [PtrWidth-1:0] ptr;
        bit                  found;
        test_name = "full_and_fair";
        for (int i = 0; i < NumEntries; i++) begin
            rand_req(exp_reqs[i]);
            // Distinct line bits keep the payloads apart
            exp_reqs[i].addr[RTAB_OFFSET_WIDTH +: PtrWidth] = PtrWidth'(i);
            seen[i] = 1'b0;
            alloc_entry(exp_reqs[i], '0, 1'b0);
        end
        check_bit("full_o", 1'b1, full);
        check_bit("empty_o when full", 1'b0, empty);
        repeat (NumEntries) begin
            pop_take(1'b1, got, ptr);
            found = 1'b0;
            for (int i = 0; i < NumEntries; i++) begin
                if (!found && !seen[i] && exp_reqs[i] == got) begin
                    seen[i] = 1'b1;
                    found   = 1'b1;
                    // Entries were filled from the lowest index upwards
                    check_ptr("pointer of popped payload", PtrWidth'(i), ptr);
                end
            end
            if (!found) begin
                $display("ERROR in %s: popped payload %h was not allocated or came out twice",
                         test_name, got);
                err_count++;
            end
            pop_commit_entry(ptr);
        end
        check_bit("empty_o after all commits", 1'b1, empty);
        check_bit("full_o after all commits", 1'b0, full);
    endtask

    initial begin
        seed         = 31;
        err_count    = 0;
        test_name    = "reset";
        check_nline  = '0;
        alloc        = 1'b0;
        alloc_link   = 1'b0;
        alloc_req    = '0;
        alloc_deps   = '0;
        pop_ready    = 1'b0;
        pop_commit   = 1'b0;
        pop_rback    = 1'b0;
        pop_done_ptr = '0;
        rback_deps   = '0;
        refill       = 1'b0;
        refill_nline = '0;
        miss_ready   = 1'b0;
        wait (rst_n === 1'b1);
        @(negedge clk);
        single_entry();
        list_order();
        refill_dependency();
        rollback_replay();
        full_and_fair();
        $display("Checks finished with %0d errors", err_count);
        if (err_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Watchdog sized from the test count and a per-test cycle budget
    initial begin
        #(TestCount * CyclesPerTest * ClkPeriodNs);
        $display("ERROR: run hung and did not finish within %0d ns",
                 TestCount * CyclesPerTest * ClkPeriodNs);
        $display("Test FAILED");
        $finish;
    end

endmodule

/* tests/tb_clock_gen.sv */
/*
 * Clock and active-low reset for the testbench.
 * Reset is released on a falling edge after ResetCycles rising edges.
 */
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PeriodNs    = 10,
    parameter int ResetCycles = 3
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #(PeriodNs / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_no = 1'b0;
        repeat (ResetCycles) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1;
    end

endmodule
